// File: design/dcachePkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data cache shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package dcachePkg;

    localparam int addrW        = 32;
    localparam int xlen         = 64;
    localparam int maskW        = xlen / 8;
    localparam int beatsPerLine = 4;
    localparam int lineW        = beatsPerLine * xlen;
    localparam int offsetW      = 5;

    // top nibble of the cacheable window
    localparam logic [3:0] cacheRegion = 4'h8;

    typedef enum logic {
        opLoad,
        opStore
    } memOp_e;

    typedef enum logic [2:0] {
        stIdle,
        stCompare,
        stWriteBack,
        stMiss,
        stRefill,
        stReplace,
        stUncached
    } cacheState_e;

    typedef struct packed {
        memOp_e             op;
        logic [addrW-1:0]   addr;
        logic [xlen-1:0]    wrData;
        logic [maskW-1:0]   wrMask;
    } cpuReq_t;

    // len is beats minus one
    typedef struct packed {
        logic               valid;
        logic [addrW-1:0]   addr;
        logic [7:0]         len;
    } busRdReq_t;

    typedef struct packed {
        logic               valid;
        logic [addrW-1:0]   addr;
        logic [lineW-1:0]   data;
        logic [maskW-1:0]   mask;
        logic [7:0]         len;
    } busWrReq_t;

    typedef logic [beatsPerLine-1:0][xlen-1:0] lineData_t;

endpackage

// File: design/dcacheCtrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data cache controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dcacheCtrl #(
    parameter int  numSets = 64,
    localparam int idxW    = $clog2(numSets),
    localparam int tagW    = dcachePkg::addrW - dcachePkg::offsetW - idxW
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          reqValid_i,
    input  dcachePkg::cpuReq_t            req_i,
    input  logic                          hit_i,
    input  logic                          victimDirty_i,
    input  logic [tagW-1:0]               victimTag_i,
    input  logic [dcachePkg::xlen-1:0]    hitWord_i,
    input  dcachePkg::lineData_t          victimLine_i,
    input  logic                          busRdReady_i,
    input  logic                          busRdValid_i,
    input  logic                          busRdLast_i,
    input  logic [dcachePkg::xlen-1:0]    busRdData_i,
    input  logic                          busWrReady_i,
    output logic                          ready_o,
    output logic                          respValid_o,
    output logic [dcachePkg::xlen-1:0]    rdData_o,
    output dcachePkg::busRdReq_t          busRd_o,
    output dcachePkg::busWrReq_t          busWr_o,
    output logic [dcachePkg::addrW-1:0]   lookupAddr_o,
    output logic [dcachePkg::xlen-1:0]    storeData_o,
    output logic [dcachePkg::maskW-1:0]   storeMask_o,
    output logic                          storeWrEn_o,
    output logic                          fillEn_o,
    output logic                          refillActive_o
);

    dcachePkg::cacheState_e stateQ, stateD;
    dcachePkg::cpuReq_t     reqQ;
    logic                   rdIssuedQ;
    logic                   isStore;
    logic                   cacheable;
    logic                   uncachedSt;

    assign isStore    = reqQ.op == dcachePkg::opStore;
    assign cacheable  = req_i.addr[dcachePkg::addrW-1 -: 4] == dcachePkg::cacheRegion;
    assign uncachedSt = stateQ == dcachePkg::stUncached;

    // store word and mask lined up with the byte offset
    assign storeData_o  = reqQ.wrData << {reqQ.addr[2:0], 3'b000};
    assign storeMask_o  = reqQ.wrMask << reqQ.addr[2:0];
    assign lookupAddr_o = reqQ.addr;

    assign ready_o        = stateQ == dcachePkg::stIdle;
    assign storeWrEn_o    = (stateQ == dcachePkg::stCompare) && hit_i && isStore;
    assign fillEn_o       = stateQ == dcachePkg::stReplace;
    assign refillActive_o = stateQ == dcachePkg::stRefill;

    assign respValid_o = ((stateQ == dcachePkg::stCompare) && hit_i)
                       || (uncachedSt && isStore && busWrReady_i)
                       || (uncachedSt && !isStore && rdIssuedQ && busRdValid_i && busRdLast_i);

    always_comb begin
        if (!respValid_o || isStore) begin
            rdData_o = '0;
        end else if (uncachedSt) begin
            rdData_o = busRdData_i;
        end else begin
            rdData_o = hitWord_i;
        end
    end

    always_comb begin
        stateD = stateQ;
        case (stateQ)
            dcachePkg::stIdle:
                if (reqValid_i) begin
                    stateD = cacheable ? dcachePkg::stCompare : dcachePkg::stUncached;
                end
            dcachePkg::stCompare:
                if (hit_i) begin
                    stateD = dcachePkg::stIdle;
                end else if (victimDirty_i) begin
                    stateD = dcachePkg::stWriteBack;
                end else begin
                    stateD = dcachePkg::stMiss;
                end
            dcachePkg::stWriteBack:
                if (busWrReady_i) stateD = dcachePkg::stMiss;
            dcachePkg::stMiss:
                if (busRdReady_i) stateD = dcachePkg::stRefill;
            dcachePkg::stRefill:
                if (busRdValid_i && busRdLast_i) stateD = dcachePkg::stReplace;
            // lookup again after the fill, which now hits
            dcachePkg::stReplace:
                stateD = dcachePkg::stCompare;
            dcachePkg::stUncached:
                if (respValid_o) stateD = dcachePkg::stIdle;
            default:
                stateD = dcachePkg::stIdle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stateQ    <= dcachePkg::stIdle;
            rdIssuedQ <= 1'b0;
        end else begin
            stateQ <= stateD;
            if (!uncachedSt || respValid_o) begin
                rdIssuedQ <= 1'b0;
            end else if (busRd_o.valid && busRdReady_i) begin
                rdIssuedQ <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ready_o && reqValid_i) begin
            reqQ <= req_i;
        end
    end

    always_comb begin
        busRd_o.valid = (stateQ == dcachePkg::stMiss) || (uncachedSt && !isStore && !rdIssuedQ);
        if (uncachedSt) begin
            busRd_o.addr = reqQ.addr;
            busRd_o.len  = 8'd0;
        end else begin
            busRd_o.addr = {reqQ.addr[dcachePkg::addrW-1:dcachePkg::offsetW],
                            {dcachePkg::offsetW{1'b0}}};
            busRd_o.len  = 8'(dcachePkg::beatsPerLine - 1);
        end
    end

    always_comb begin
        busWr_o.valid = (stateQ == dcachePkg::stWriteBack) || (uncachedSt && isStore);
        if (stateQ == dcachePkg::stWriteBack) begin
            busWr_o.addr = {victimTag_i, reqQ.addr[dcachePkg::offsetW +: idxW],
                            {dcachePkg::offsetW{1'b0}}};
            busWr_o.data = victimLine_i;
            busWr_o.mask = '1;
            busWr_o.len  = 8'(dcachePkg::beatsPerLine - 1);
        end else begin
            // single beat, word in the low slot
            busWr_o.addr = {reqQ.addr[dcachePkg::addrW-1:3], 3'b000};
            busWr_o.data = dcachePkg::lineW'(storeData_o);
            busWr_o.mask = storeMask_o;
            busWr_o.len  = 8'd0;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !(busRd_o.valid && busWr_o.valid));

    // a response closes the request and frees the cache next cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        respValid_o |-> (stateQ != dcachePkg::stIdle) ##1 ready_o);

endmodule

// File: design/tagStore.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tag and state arrays
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tagStore #(
    parameter int  numSets = 64,
    localparam int idxW    = $clog2(numSets),
    localparam int tagW    = dcachePkg::addrW - dcachePkg::offsetW - idxW
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [dcachePkg::addrW-1:0]   lookupAddr_i,
    input  logic                          storeWrEn_i,
    input  logic                          fillEn_i,
    output logic                          hit_o,
    output logic                          hitWay_o,
    output logic                          victimWay_o,
    output logic                          victimDirty_o,
    output logic [tagW-1:0]               victimTag_o
);

    logic [tagW-1:0]    tagArr [2][numSets];
    logic [numSets-1:0] validQ [2];
    logic [numSets-1:0] dirtyQ [2];
    // way most recently used per set
    logic [numSets-1:0] mruQ;
    logic [idxW-1:0]    idx;
    logic [tagW-1:0]    tag;
    logic [1:0]         wayHit;

    assign idx = lookupAddr_i[dcachePkg::offsetW +: idxW];
    assign tag = lookupAddr_i[dcachePkg::addrW-1 -: tagW];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wayHit[w] = validQ[w][idx] && (tagArr[w][idx] == tag);
        end
    end

    assign hit_o    = |wayHit;
    assign hitWay_o = wayHit[1];

    // free way first, else the older one
    always_comb begin
        if (!validQ[0][idx]) begin
            victimWay_o = 1'b0;
        end else if (!validQ[1][idx]) begin
            victimWay_o = 1'b1;
        end else begin
            victimWay_o = !mruQ[idx];
        end
    end

    assign victimDirty_o = validQ[victimWay_o][idx] && dirtyQ[victimWay_o][idx];
    assign victimTag_o   = tagArr[victimWay_o][idx];

    always_ff @(posedge clk) begin
        if (fillEn_i) begin
            tagArr[victimWay_o][idx] <= tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            validQ <= '{default: '0};
            dirtyQ <= '{default: '0};
            mruQ   <= '0;
        end else if (fillEn_i) begin
            validQ[victimWay_o][idx] <= 1'b1;
            dirtyQ[victimWay_o][idx] <= 1'b0;
            mruQ[idx]                <= victimWay_o;
        end else if (storeWrEn_i) begin
            dirtyQ[hitWay_o][idx] <= 1'b1;
            mruQ[idx]             <= hitWay_o;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(wayHit[0] && wayHit[1]));

endmodule

// File: design/dataStore.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Line data arrays
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dataStore #(
    parameter int  numSets = 64,
    localparam int idxW    = $clog2(numSets),
    localparam int wordW   = $clog2(dcachePkg::beatsPerLine)
) (
    input  logic                          clk,
    input  logic [dcachePkg::addrW-1:0]   lookupAddr_i,
    input  logic                          hitWay_i,
    input  logic                          victimWay_i,
    input  logic                          storeWrEn_i,
    input  logic [dcachePkg::xlen-1:0]    storeData_i,
    input  logic [dcachePkg::maskW-1:0]   storeMask_i,
    input  logic                          fillEn_i,
    input  dcachePkg::lineData_t          fillLine_i,
    output logic [dcachePkg::xlen-1:0]    hitWord_o,
    output dcachePkg::lineData_t          victimLine_o
);

    dcachePkg::lineData_t lineArr [2][numSets];
    logic [idxW-1:0]      idx;
    logic [wordW-1:0]     wordSel;

    assign idx     = lookupAddr_i[dcachePkg::offsetW +: idxW];
    assign wordSel = lookupAddr_i[dcachePkg::offsetW-1 -: wordW];

    always_ff @(posedge clk) begin
        if (fillEn_i) begin
            lineArr[victimWay_i][idx] <= fillLine_i;
        end else if (storeWrEn_i) begin
            // only enabled bytes of the addressed word
            for (int b = 0; b < dcachePkg::maskW; b++) begin
                if (storeMask_i[b]) begin
                    lineArr[hitWay_i][idx][wordSel][b*8 +: 8] <= storeData_i[b*8 +: 8];
                end
            end
        end
    end

    assign hitWord_o    = lineArr[hitWay_i][idx][wordSel];
    assign victimLine_o = lineArr[victimWay_i][idx];

endmodule

// File: design/refillBuffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Refill line buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module refillBuffer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          refillActive_i,
    input  logic                          busRdValid_i,
    input  logic [dcachePkg::xlen-1:0]    busRdData_i,
    output dcachePkg::lineData_t          line_o
);

    // one extra bit so a full line is visible
    localparam int cntW = $clog2(dcachePkg::beatsPerLine) + 1;

    logic [cntW-1:0] beatCnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beatCnt <= '0;
        end else if (!refillActive_i) begin
            beatCnt <= '0;
        end else if (busRdValid_i) begin
            beatCnt <= beatCnt + 1'b1;
        end
    end

    // beats land in address order
    always_ff @(posedge clk) begin
        if (refillActive_i && busRdValid_i) begin
            line_o[beatCnt[cntW-2:0]] <= busRdData_i;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        refillActive_i && busRdValid_i |-> beatCnt < cntW'(dcachePkg::beatsPerLine));

endmodule

// File: design/dcacheTop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data cache top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dcacheTop #(
    parameter int  numSets = 64,
    localparam int tagW    = dcachePkg::addrW - dcachePkg::offsetW - $clog2(numSets)
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          reqValid_i,
    input  dcachePkg::cpuReq_t            req_i,
    output logic                          ready_o,
    output logic                          respValid_o,
    output logic [dcachePkg::xlen-1:0]    rdData_o,
    output dcachePkg::busRdReq_t          busRd_o,
    input  logic                          busRdReady_i,
    input  logic                          busRdValid_i,
    input  logic                          busRdLast_i,
    input  logic [dcachePkg::xlen-1:0]    busRdData_i,
    output dcachePkg::busWrReq_t          busWr_o,
    input  logic                          busWrReady_i
);

    logic [dcachePkg::addrW-1:0] lookupAddr;
    logic                        hit, hitWay, victimWay, victimDirty;
    logic [tagW-1:0]             victimTag;
    logic [dcachePkg::xlen-1:0]  hitWord, storeData;
    logic [dcachePkg::maskW-1:0] storeMask;
    logic                        storeWrEn, fillEn, refillActive;
    dcachePkg::lineData_t        victimLine, fillLine;

    dcacheCtrl #(.numSets(numSets)) uCtrl (
        .clk, .rst_n, .reqValid_i, .req_i,
        .hit_i(hit), .victimDirty_i(victimDirty), .victimTag_i(victimTag),
        .hitWord_i(hitWord), .victimLine_i(victimLine),
        .busRdReady_i, .busRdValid_i, .busRdLast_i, .busRdData_i, .busWrReady_i,
        .ready_o, .respValid_o, .rdData_o, .busRd_o, .busWr_o,
        .lookupAddr_o(lookupAddr), .storeData_o(storeData), .storeMask_o(storeMask),
        .storeWrEn_o(storeWrEn), .fillEn_o(fillEn), .refillActive_o(refillActive)
    );

    tagStore #(.numSets(numSets)) uTags (
        .clk, .rst_n, .lookupAddr_i(lookupAddr), .storeWrEn_i(storeWrEn), .fillEn_i(fillEn),
        .hit_o(hit), .hitWay_o(hitWay), .victimWay_o(victimWay),
        .victimDirty_o(victimDirty), .victimTag_o(victimTag)
    );

    dataStore #(.numSets(numSets)) uData (
        .clk, .lookupAddr_i(lookupAddr), .hitWay_i(hitWay), .victimWay_i(victimWay),
        .storeWrEn_i(storeWrEn), .storeData_i(storeData), .storeMask_i(storeMask),
        .fillEn_i(fillEn), .fillLine_i(fillLine),
        .hitWord_o(hitWord), .victimLine_o(victimLine)
    );

    refillBuffer uRefill (
        .clk, .rst_n, .refillActive_i(refillActive), .busRdValid_i, .busRdData_i,
        .line_o(fillLine)
    );

endmodule

// File: bench/tbClock.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tbClock #(
    parameter int halfPeriod = 50
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(halfPeriod) clk = ~clk;

endmodule

// File: bench/dcacheTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data cache testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dcacheTb;

    localparam int waitLimit = 200;

    logic clk, rst_n, reqValid_i, ready_o, respValid_o;
    logic busRdReady_i, busRdValid_i, busRdLast_i, busWrReady_i;
    logic [63:0] rdData_o, busRdData_i;
    dcachePkg::cpuReq_t   req_i;
    dcachePkg::busRdReq_t busRd_o;
    dcachePkg::busWrReq_t busWr_o;

    // reference model state, one bit per set
    logic [20:0] refTag [2][64];
    logic [63:0] refValid [2];
    logic [63:0] refDirty [2];
    logic [63:0] refMru;
    dcachePkg::lineData_t refLine [2][64];
    logic [63:0] refMem [logic [28:0]];

    // expectations for the access in flight
    string testName = "reset";
    logic expCached, expHit, expWb;
    logic [63:0] expRdData;
    logic [39:0] expRdReq;
    dcachePkg::busWrReq_t expWrReq;
    int errors = 0;
    int accesses = 0;
    int reqSeen = 0;
    int wrHandshakes = 0;
    int wrBase = 0;
    int beatsLeft = 0;
    logic [31:0] rdAddr;

    tbClock uClock (.clk(clk));

    dcacheTop #(.numSets(64)) DUT (
        .clk, .rst_n, .reqValid_i, .req_i, .ready_o, .respValid_o, .rdData_o,
        .busRd_o, .busRdReady_i, .busRdValid_i, .busRdLast_i, .busRdData_i,
        .busWr_o, .busWrReady_i
    );

    task automatic reportError(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    // untouched memory holds a pattern of the word address
    function automatic logic [63:0] memWord(input logic [31:0] addr);
        if (refMem.exists(addr[31:3])) begin
            return refMem[addr[31:3]];
        end
        return {addr[31:3], 3'b000, ~addr[31:3], 3'b111};
    endfunction

    function automatic logic [63:0] mergeBytes(input logic [63:0] old, input logic [63:0] data,
                                               input logic [7:0] mask);
        logic [63:0] res;
        res = old;
        for (int b = 0; b < 8; b++) begin
            if (mask[b]) res[b*8 +: 8] = data[b*8 +: 8];
        end
        return res;
    endfunction

    task automatic predict(input dcachePkg::memOp_e op, input logic [31:0] addr,
                           input logic [63:0] data, input logic [7:0] mask);
        logic [5:0]  idx;
        logic [20:0] tag;
        logic [1:0]  word;
        logic        way;
        logic [63:0] sData;
        logic [7:0]  sMask;
        idx   = addr[10:5];
        tag   = addr[31:11];
        word  = addr[4:3];
        sData = data << {addr[2:0], 3'b000};
        sMask = mask << addr[2:0];
        expCached = addr[31:28] == 4'h8;
        expHit    = 1'b0;
        expWb     = 1'b0;
        expRdData = '0;
        expWrReq  = '0;
        expRdReq  = expCached ? {addr[31:5], 5'b0, 8'd3} : {addr, 8'd0};
        way       = 1'b0;
        if (!expCached) begin
            if (op == dcachePkg::opLoad) begin
                expRdData = memWord(addr);
            end else begin
                expWrReq = '{valid: 1'b1, addr: {addr[31:3], 3'b000}, data: 256'(sData),
                             mask: sMask, len: 8'd0};
                refMem[addr[31:3]] = mergeBytes(memWord(addr), sData, sMask);
            end
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (refValid[w][idx] && refTag[w][idx] == tag) begin
                    expHit = 1'b1;
                    way    = 1'(w);
                end
            end
            if (!expHit) begin
                // invalid way first, else the least recently used
                way = !refValid[0][idx] ? 1'b0 : (!refValid[1][idx] ? 1'b1 : !refMru[idx]);
                if (refValid[way][idx] && refDirty[way][idx]) begin
                    expWb    = 1'b1;
                    expWrReq = '{valid: 1'b1, addr: {refTag[way][idx], idx, 5'b0},
                                 data: refLine[way][idx], mask: 8'hFF, len: 8'd3};
                    for (int i = 0; i < 4; i++) begin
                        refMem[{refTag[way][idx], idx, 2'(i)}] = refLine[way][idx][i];
                    end
                end
                for (int i = 0; i < 4; i++) begin
                    refLine[way][idx][i] = memWord({addr[31:5], 2'(i), 3'b000});
                end
                refTag[way][idx]   = tag;
                refValid[way][idx] = 1'b1;
                refDirty[way][idx] = 1'b0;
                refMru[idx]        = way;
            end
            if (op == dcachePkg::opStore) begin
                refLine[way][idx][word] = mergeBytes(refLine[way][idx][word], sData, sMask);
                refDirty[way][idx] = 1'b1;
                refMru[idx]        = way;
            end else begin
                expRdData = refLine[way][idx][word];
            end
        end
    endtask

    task automatic waitReady(input string what);
        int waitCnt;
        waitCnt = 0;
        while (!ready_o && waitCnt < waitLimit) begin
            @(negedge clk);
            waitCnt++;
        end
        if (!ready_o) reportError($sformatf("%s: cache not ready %s", testName, what));
    endtask

    task automatic access(input string name, input dcachePkg::memOp_e op,
                          input logic [31:0] addr, input logic [63:0] data,
                          input logic [7:0] mask);
        waitReady("before the request");
        testName = name;
        predict(op, addr, data, mask);
        reqSeen = 0;
        wrBase  = wrHandshakes;
        req_i   = '{op: op, addr: addr, wrData: data, wrMask: mask};
        reqValid_i = 1'b1;
        @(negedge clk);
        reqValid_i = 1'b0;
        accesses++;
        waitReady("after the request, no response came");
    endtask

    // memory model, random ready delays and beat gaps
    initial begin
        busRdReady_i = 1'b0;
        busWrReady_i = 1'b0;
        busRdValid_i = 1'b0;
        busRdLast_i  = 1'b0;
        busRdData_i  = '0;
        forever begin
            @(negedge clk);
            busRdReady_i = 1'b0;
            busWrReady_i = 1'b0;
            busRdValid_i = 1'b0;
            busRdLast_i  = 1'b0;
            if (beatsLeft > 0) begin
                if ($urandom % 4 != 0) begin
                    busRdValid_i = 1'b1;
                    busRdData_i  = memWord(rdAddr);
                    busRdLast_i  = beatsLeft == 1;
                    rdAddr       = rdAddr + 8;
                    beatsLeft--;
                end
            end else if (busWr_o.valid && $urandom % 3 == 0) begin
                busWrReady_i = 1'b1;
                reqSeen++;
            end else if (busRd_o.valid && $urandom % 3 == 0) begin
                busRdReady_i = 1'b1;
                reqSeen++;
                rdAddr    = busRd_o.addr;
                beatsLeft = busRd_o.len + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (busWr_o.valid && busWrReady_i) wrHandshakes <= wrHandshakes + 1;
    end

    assert property (@(posedge clk)
        !rst_n |-> ready_o && !respValid_o && !busRd_o.valid && !busWr_o.valid)
        else reportError("cache outputs not idle during reset");

    assert property (@(posedge clk) disable iff (!rst_n) reqValid_i && ready_o |=> !ready_o)
        else reportError($sformatf("%s: ready stayed high after acceptance", testName));

    assert property (@(posedge clk) disable iff (!rst_n) $rose(ready_o) |-> $past(respValid_o))
        else reportError($sformatf("%s: ready returned without a response", testName));

    // a hit answers in the next cycle without touching the bus
    assert property (@(posedge clk) disable iff (!rst_n)
        reqValid_i && ready_o && expHit |=> respValid_o && !busRd_o.valid && !busWr_o.valid)
        else reportError($sformatf("%s: hit response late or with bus traffic", testName));

    assert property (@(posedge clk) disable iff (!rst_n) respValid_o |-> rdData_o == expRdData)
        else reportError($sformatf("Mismatch %s rdData: expected %h, actual %h",
                                   testName, expRdData, $sampled(rdData_o)));

    assert property (@(posedge clk) disable iff (!rst_n) respValid_o && !expHit |-> reqSeen != 0)
        else reportError($sformatf("%s: response came with no bus transfer", testName));

    assert property (@(posedge clk) disable iff (!rst_n)
        busRd_o.valid |-> {busRd_o.addr, busRd_o.len} == expRdReq)
        else reportError($sformatf("Mismatch %s busRd addr/len: expected %h, actual %h",
                                   testName, expRdReq, $sampled({busRd_o.addr, busRd_o.len})));

    assert property (@(posedge clk) disable iff (!rst_n)
        busRd_o.valid && expCached |-> (wrHandshakes != wrBase) == expWb)
        else reportError($sformatf("%s: refill issued out of order with write-back", testName));

    assert property (@(posedge clk) disable iff (!rst_n) busWr_o.valid |-> busWr_o == expWrReq)
        else reportError($sformatf("Mismatch %s busWr: expected %h, actual %h",
                                   testName, expWrReq, $sampled(busWr_o)));

    initial begin
        void'($urandom(32'h5fae52e5));
        rst_n      = 1'b0;
        reqValid_i = 1'b0;
        req_i      = '0;
        refValid   = '{default: '0};
        refDirty   = '{default: '0};
        refMru     = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        access("loadMiss", dcachePkg::opLoad, 32'h8000_0048, '0, '0);
        access("loadHit", dcachePkg::opLoad, 32'h8000_0050, '0, '0);
        access("storeHit", dcachePkg::opStore, 32'h8000_004B, {$urandom, $urandom}, 8'h0F);
        access("loadMerge", dcachePkg::opLoad, 32'h8000_0048, '0, '0);
        // three lines in set 2, the first one dirty
        access("fillSecondWay", dcachePkg::opLoad, 32'h8000_0840, '0, '0);
        access("evictDirty", dcachePkg::opLoad, 32'h8000_1058, '0, '0);
        access("storeSecondWay", dcachePkg::opStore, 32'h8000_0850, {$urandom, $urandom}, 8'hFF);
        access("evictClean", dcachePkg::opLoad, 32'h8000_0040, '0, '0);
        access("evictStored", dcachePkg::opLoad, 32'h8000_1040, '0, '0);
        access("storeMiss", dcachePkg::opStore, 32'h8000_2088, {$urandom, $urandom}, 8'hC3);
        access("uncachedLoad", dcachePkg::opLoad, 32'h1000_0013, '0, '0);
        access("uncachedLoadAgain", dcachePkg::opLoad, 32'h1000_0013, '0, '0);
        access("uncachedStore", dcachePkg::opStore, 32'h2000_0006, {$urandom, $urandom}, 8'h03);
        access("uncachedReadBack", dcachePkg::opLoad, 32'h2000_0000, '0, '0);
        for (int n = 0; n < 24; n++) begin
            access("random", ($urandom % 2) ? dcachePkg::opStore : dcachePkg::opLoad,
                   32'h8000_0000 | (($urandom % 4) << 11) | (($urandom % 2) << 5)
                   | ($urandom % 32), {$urandom, $urandom}, 8'($urandom));
        end
        repeat (2) @(negedge clk);
        $display("Errors: %0d, accesses: %0d", errors, accesses);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
design/dcachePkg.sv
design/dcacheCtrl.sv
design/tagStore.sv
design/dataStore.sv
design/refillBuffer.sv
design/dcacheTop.sv
bench/tbClock.sv
bench/dcacheTb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - files:
      - design/dcachePkg.sv
      - design/dcacheCtrl.sv
      - design/tagStore.sv
      - design/dataStore.sv
      - design/refillBuffer.sv
      - design/dcacheTop.sv
  - target: test
    files:
      - bench/tbClock.sv
      - bench/dcacheTb.sv
